//--- files.f
+incdir+.
box_pkg.sv
window_7x7_datapath.sv
pixel_frame_buffer.sv
window_sum_tree.sv
box_sequencer.sv
wb_box_regs.sv
box_filter_top.sv
tb_box_filter.sv

//--- Makefile
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check sim.log"
	@echo "  clean  remove the build directory and sim.log"

test:
	verilator --binary --timing --assert -Wno-fatal -f files.f \
		--top-module tb_box_filter -Mdir obj_dir -o sim_box
	./obj_dir/sim_box | tee sim.log
	grep -q "All tests passed" sim.log

clean:
	rm -rf obj_dir sim.log

//--- tb_box_filter.sv
`include "box_cfg.svh"

module tb_box_filter;

    timeunit 1ns;
    timeprecision 1ps;

    // Five frames with their pixel loads, reads and polling stay well below this.
    localparam int TIMEOUT_CYCLES = 20000;
    // Start pulse to done: clear, seven rows of preload and run, then the drain.
    localparam int FRAME_CYCLES = 1 + `BOX_DIM * (`BOX_PRELOAD + `BOX_DIM) + `BOX_PIPE;

    logic              clk;
    logic              rst_n;
    logic              cyc_i;
    logic              stb_i;
    logic              we_i;
    box_pkg::wb_adr_t  adr_i;
    box_pkg::wb_data_t dat_i;
    box_pkg::wb_data_t dat_o;
    logic              ack_o;

    box_pkg::pixel_t image [`BOX_PIXELS];   // What the DUT should hold.
    logic [31:0]     lfsr_state;
    int              errors;
    int              tests_run;
    int              tests_failed;
    int              cycles;

    box_filter_top uut (
        .clk(clk), .rst_n(rst_n), .cyc_i(cyc_i), .stb_i(stb_i), .we_i(we_i),
        .adr_i(adr_i), .dat_i(dat_i), .dat_o(dat_o), .ack_o(ack_o)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: the run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
        $display("Some tests failed");
        $finish;
    end

    // Taps at bits 32, 22, 2 and 1.
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // Reference box filter over the pixels that lie inside the tile.
    function automatic int box_sum(input int row, input int col);
        int sum;
        sum = 0;
        for (int r = row - `BOX_HALF; r <= row + `BOX_HALF; r++) begin
            for (int c = col - `BOX_HALF; c <= col + `BOX_HALF; c++) begin
                if (r >= 0 && r < `BOX_DIM && c >= 0 && c < `BOX_DIM)
                    sum += int'(image[r * `BOX_DIM + c]);
            end
        end
        return sum;
    endfunction

    task automatic check_value(input string name, input int expected, input int actual);
        assert (expected == actual) else begin
            $display("CHECK FAILED %s expected %0d actual %0d", name, expected, actual);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("%-20s ok", name);
        end else begin
            tests_failed++;
            $display("%-20s failed with %0d errors", name, errors - errors_before);
        end
    endtask

    // Called on a falling edge, returns on a falling edge with the bus idle.
    task automatic wb_write(input box_pkg::wb_adr_t adr, input box_pkg::wb_data_t data);
        cyc_i = 1'b1;
        stb_i = 1'b1;
        we_i  = 1'b1;
        adr_i = adr;
        dat_i = data;
        @(negedge clk);
        while (!ack_o) @(negedge clk);
        cyc_i = 1'b0;
        stb_i = 1'b0;
        we_i  = 1'b0;
        @(negedge clk);
    endtask

    task automatic wb_read(input box_pkg::wb_adr_t adr, output box_pkg::wb_data_t data);
        cyc_i = 1'b1;
        stb_i = 1'b1;
        we_i  = 1'b0;
        adr_i = adr;
        @(negedge clk);
        while (!ack_o) @(negedge clk);
        data  = dat_o;
        cyc_i = 1'b0;
        stb_i = 1'b0;
        @(negedge clk);
    endtask

    task automatic fill_random();
        for (int i = 0; i < `BOX_PIXELS; i++) begin
            for (int b = 0; b < 8; b++) begin
                lfsr_state = lfsr_step(lfsr_state);
                image[i]   = {image[i][6:0], lfsr_state[0]};
            end
        end
    endtask

    task automatic load_image();
        for (int i = 0; i < `BOX_PIXELS; i++) wb_write(8'(i), {8'h00, image[i]});
    endtask

    task automatic start_and_wait();
        box_pkg::wb_data_t status;
        wb_write(`BOX_ADR_CTRL, 16'h0001);
        status = '0;
        while (!status[1]) wb_read(`BOX_ADR_STAT, status);
    endtask

    task automatic compare_results(input string name);
        box_pkg::wb_data_t data;
        for (int i = 0; i < `BOX_PIXELS; i++) begin
            wb_read(8'(`BOX_ADR_RES + i), data);
            check_value(name, box_sum(i / `BOX_DIM, i % `BOX_DIM), int'(data));
        end
    endtask

    task automatic after_reset_zeros();
        box_pkg::wb_data_t data;
        int                start_errors;
        start_errors = errors;
        wb_read(`BOX_ADR_STAT, data);
        check_value("reset status", 0, int'(data));
        for (int i = 0; i < `BOX_PIXELS; i++) begin
            wb_read(8'(`BOX_ADR_RES + i), data);
            check_value("reset result", 0, int'(data));
        end
        report_test("after_reset_zeros", start_errors);
    endtask

    task automatic ones_tap_counts();
        box_pkg::wb_data_t data;
        int                start_errors;
        start_errors = errors;
        foreach (image[i]) image[i] = 8'd1;
        load_image();
        start_and_wait();
        compare_results("ones tap count");
        wb_read(`BOX_ADR_RES, data);
        check_value("ones corner", 16, int'(data));
        wb_read(8'(`BOX_ADR_RES + 3), data);   // Top edge centre.
        check_value("ones edge", 28, int'(data));
        wb_read(8'(`BOX_ADR_RES + 24), data);
        check_value("ones centre", 49, int'(data));
        report_test("ones_tap_counts", start_errors);
    endtask

    task automatic random_image_sums();
        int start_errors;
        start_errors = errors;
        fill_random();
        load_image();
        start_and_wait();
        compare_results("random sums");
        report_test("random_image_sums", start_errors);
    endtask

    task automatic full_scale_image();
        box_pkg::wb_data_t data;
        int                start_errors;
        start_errors = errors;
        foreach (image[i]) image[i] = 8'd255;
        load_image();
        start_and_wait();
        compare_results("full scale");
        wb_read(8'(`BOX_ADR_RES + 24), data);
        check_value("full scale centre", 12495, int'(data));
        report_test("full_scale_image", start_errors);
    endtask

    task automatic busy_lockout();
        box_pkg::wb_data_t status;
        int                start_errors;
        int                start_cycle;
        start_errors = errors;
        fill_random();
        load_image();
        start_cycle = cycles;
        wb_write(`BOX_ADR_CTRL, 16'h0001);
        wb_read(`BOX_ADR_STAT, status);
        check_value("busy after start", 1, int'(status[0]));
        // These land mid-frame and must not reach the tile.
        for (int i = 0; i < `BOX_DIM; i++) wb_write(8'(i), 16'h00aa);
        wb_write(`BOX_ADR_CTRL, 16'h0001);
        status = '0;
        while (!status[1]) wb_read(`BOX_ADR_STAT, status);
        check_value("done status", 2, int'(status));
        // A restarted frame would run a whole frame past the second start.
        assert (cycles - start_cycle <= FRAME_CYCLES + 8) else begin
            $display("Done came %0d cycles after the start, so the start while busy restarted it",
                     cycles - start_cycle);
            errors++;
        end
        compare_results("locked frame");
        fill_random();
        load_image();
        start_and_wait();
        compare_results("second frame");
        report_test("busy_lockout", start_errors);
    endtask

    initial begin
        rst_n        = 1'b0;
        cyc_i        = 1'b0;
        stb_i        = 1'b0;
        we_i         = 1'b0;
        adr_i        = '0;
        dat_i        = '0;
        lfsr_state   = 32'h8d45fd18;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        foreach (image[i]) image[i] = '0;
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        after_reset_zeros();
        ones_tap_counts();
        random_image_sums();
        full_scale_image();
        busy_lockout();
        $display("tests run %0d, tests failed %0d, checks failed %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

//--- box_filter_top.sv
`include "box_cfg.svh"

module box_filter_top (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              cyc_i,
    input  logic              stb_i,
    input  logic              we_i,
    input  box_pkg::wb_adr_t  adr_i,
    input  box_pkg::wb_data_t dat_i,
    output box_pkg::wb_data_t dat_o,
    output logic              ack_o
);

    box_pkg::pixel_wr_t    wr;
    box_pkg::column_t      column;
    box_pkg::window_beat_t win;
    box_pkg::result_beat_t res;
    box_pkg::coord_t       feed_row;
    logic [3:0]            feed_col;
    logic                  start;
    logic                  busy;
    logic                  done;
    logic                  load_en;
    logic                  o_en;
    logic                  count_en;
    logic                  reset_en;
    logic                  finish_en;
    logic                  padding_fi;

    wb_box_regs u_regs (
        .clk(clk), .rst_n(rst_n), .cyc_i(cyc_i), .stb_i(stb_i), .we_i(we_i),
        .adr_i(adr_i), .dat_i(dat_i), .busy_i(busy), .done_i(done), .res_i(res),
        .dat_o(dat_o), .ack_o(ack_o), .wr_o(wr), .start_o(start)
    );

    pixel_frame_buffer u_buf (
        .clk(clk), .rst_n(rst_n), .wr_i(wr),
        .feed_row_i(feed_row), .feed_col_i(feed_col), .col_o(column)
    );

    box_sequencer u_seq (
        .clk(clk), .rst_n(rst_n), .start_i(start),
        .finish_en_i(finish_en), .padding_fi_i(padding_fi),
        .load_en_o(load_en), .o_en_o(o_en), .count_en_o(count_en), .reset_en_o(reset_en),
        .feed_row_o(feed_row), .feed_col_o(feed_col), .busy_o(busy), .done_o(done)
    );

    window_7x7_datapath #(
        .ROWS(`BOX_DIM),
        .COLS(`BOX_DIM)
    ) u_win (
        .clk(clk), .rst_n(rst_n), .col_i(column),
        .load_en_i(load_en), .o_en_i(o_en), .count_en_i(count_en), .reset_en_i(reset_en),
        .win_o(win), .finish_en_o(finish_en), .padding_fi_o(padding_fi)
    );

    window_sum_tree u_tree (
        .clk(clk), .rst_n(rst_n), .win_i(win), .res_o(res)
    );

endmodule

//--- wb_box_regs.sv
`include "box_cfg.svh"

module wb_box_regs (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  cyc_i,
    input  logic                  stb_i,
    input  logic                  we_i,
    input  box_pkg::wb_adr_t      adr_i,
    input  box_pkg::wb_data_t     dat_i,
    input  logic                  busy_i,
    input  logic                  done_i,
    input  box_pkg::result_beat_t res_i,
    output box_pkg::wb_data_t     dat_o,
    output logic                  ack_o,
    output box_pkg::pixel_wr_t    wr_o,
    output logic                  start_o
);

    box_pkg::result_t  res_mem_q [`BOX_PIXELS];
    box_pkg::wb_data_t rd_data;
    logic              access;
    logic              res_hit;
    logic [5:0]        res_rd_idx;
    logic [5:0]        res_wr_idx;

    assign access = cyc_i && stb_i && !ack_o;   // The ack cycle is not a new request.

    assign wr_o.en  = access && we_i && (adr_i < `BOX_PIXELS) && !busy_i;
    assign wr_o.idx = adr_i[5:0];
    assign wr_o.pix = dat_i[7:0];
    assign start_o  = access && we_i && (adr_i == `BOX_ADR_CTRL) && dat_i[0] && !busy_i;

    assign res_hit    = (adr_i >= `BOX_ADR_RES) && (adr_i < `BOX_ADR_RES + `BOX_PIXELS);
    assign res_rd_idx = 6'(adr_i - `BOX_ADR_RES);
    assign res_wr_idx = 6'(res_i.row) * 6'(`BOX_DIM) + 6'(res_i.col);

    always_comb begin
        rd_data = '0;
        if (adr_i == `BOX_ADR_STAT) begin
            rd_data = {14'b0, done_i, busy_i};
        end else if (res_hit) begin
            rd_data = {2'b00, res_mem_q[res_rd_idx]};
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ack_o <= 1'b0;
            dat_o <= '0;
        end else begin
            ack_o <= access;
            if (access && !we_i) dat_o <= rd_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `BOX_PIXELS; i++) begin
                res_mem_q[i] <= '0;
            end
        end else if (res_i.valid) begin
            res_mem_q[res_wr_idx] <= res_i.sum;
        end
    end

    a_ack_single: assert property (@(posedge clk) disable iff (!rst_n)
        ack_o |=> !ack_o)
        else $error("ack held for two cycles");

endmodule

//--- box_sequencer.sv
`include "box_cfg.svh"

module box_sequencer (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            start_i,
    input  logic            finish_en_i,
    input  logic            padding_fi_i,
    output logic            load_en_o,
    output logic            o_en_o,
    output logic            count_en_o,
    output logic            reset_en_o,
    output box_pkg::coord_t feed_row_o,
    output logic [3:0]      feed_col_o,
    output logic            busy_o,
    output logic            done_o
);

    // Four preload columns plus seven run columns per row.
    localparam logic [3:0] LAST_COL = 4'(`BOX_PRELOAD + `BOX_DIM - 1);

    box_pkg::seq_state_t state_q;
    logic [1:0]          drain_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q    <= box_pkg::IDLE;
            feed_row_o <= '0;
            feed_col_o <= '0;
            drain_q    <= '0;
        end else begin
            case (state_q)
                box_pkg::IDLE, box_pkg::DONE: begin
                    if (start_i) state_q <= box_pkg::CLEAR;
                end
                box_pkg::CLEAR: begin
                    feed_row_o <= '0;
                    feed_col_o <= '0;
                    state_q    <= box_pkg::PRELOAD;
                end
                box_pkg::PRELOAD: begin
                    feed_col_o <= feed_col_o + 1'b1;
                    if (padding_fi_i) state_q <= box_pkg::RUN;
                end
                box_pkg::RUN: begin
                    if (feed_col_o == LAST_COL) begin
                        feed_col_o <= '0;
                        if (finish_en_i) begin   // Last window of the tile went out.
                            drain_q <= '0;
                            state_q <= box_pkg::DRAIN;
                        end else begin
                            feed_row_o <= feed_row_o + 1'b1;
                            state_q    <= box_pkg::PRELOAD;
                        end
                    end else begin
                        feed_col_o <= feed_col_o + 1'b1;
                    end
                end
                box_pkg::DRAIN: begin
                    drain_q <= drain_q + 1'b1;
                    if (drain_q == 2'(`BOX_PIPE - 1)) state_q <= box_pkg::DONE;
                end
                default: state_q <= box_pkg::IDLE;
            endcase
        end
    end

    assign load_en_o  = (state_q == box_pkg::PRELOAD) || (state_q == box_pkg::RUN);
    assign o_en_o     = (state_q == box_pkg::RUN);
    assign count_en_o = (state_q == box_pkg::PRELOAD);
    assign reset_en_o = (state_q == box_pkg::CLEAR);
    assign busy_o     = !(state_q == box_pkg::IDLE || state_q == box_pkg::DONE);
    assign done_o     = (state_q == box_pkg::DONE);

    a_start_ignored_busy: assert property (@(posedge clk) disable iff (!rst_n)
        start_i && busy_o |=> state_q != box_pkg::CLEAR)
        else $error("start restarted a running frame");

endmodule

//--- window_sum_tree.sv
`include "box_cfg.svh"

module window_sum_tree (
    input  logic                  clk,
    input  logic                  rst_n,
    input  box_pkg::window_beat_t win_i,
    output box_pkg::result_beat_t res_o
);

    // A row of seven pixels sums to at most 1785, which needs 11 bits.
    logic [`BOX_DIM-1:0][10:0] row_sum_d;
    logic [`BOX_DIM-1:0][10:0] row_sum_q;
    box_pkg::coord_t           row1_q;
    box_pkg::coord_t           col1_q;
    logic                      v1_q;
    box_pkg::result_t          total_d;

    always_comb begin
        for (int r = 0; r < `BOX_DIM; r++) begin
            row_sum_d[r] = '0;
            for (int k = 0; k < `BOX_DIM; k++) begin
                row_sum_d[r] = row_sum_d[r] + 11'(win_i.pix[r][k]);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            v1_q <= 1'b0;
        end else begin
            v1_q <= win_i.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (win_i.valid) begin
            row_sum_q <= row_sum_d;
            row1_q    <= win_i.row;
            col1_q    <= win_i.col;
        end
    end

    always_comb begin
        total_d = '0;
        for (int r = 0; r < `BOX_DIM; r++) begin
            total_d = total_d + 14'(row_sum_q[r]);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            res_o <= '0;
        end else begin
            res_o.valid <= v1_q;
            if (v1_q) begin
                res_o.sum <= total_d;   // 49 x 255 = 12495 fits in 14 bits.
                res_o.row <= row1_q;
                res_o.col <= col1_q;
            end
        end
    end

endmodule

//--- pixel_frame_buffer.sv
`include "box_cfg.svh"

module pixel_frame_buffer (
    input  logic               clk,
    input  logic               rst_n,
    input  box_pkg::pixel_wr_t wr_i,
    input  box_pkg::coord_t    feed_row_i,
    input  logic [3:0]         feed_col_i,
    output box_pkg::column_t   col_o
);

    box_pkg::pixel_t mem_q [`BOX_PIXELS];   // Row-major tile.

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `BOX_PIXELS; i++) begin
                mem_q[i] <= '0;
            end
        end else if (wr_i.en && wr_i.idx < `BOX_PIXELS) begin
            mem_q[wr_i.idx] <= wr_i.pix;
        end
    end

    // Seven rows centred on feed_row, all at one column.
    always_comb begin
        int src_row;
        for (int r = 0; r < `BOX_DIM; r++) begin
            src_row = int'(feed_row_i) + r - `BOX_HALF;
            if (src_row >= 0 && src_row < `BOX_DIM && feed_col_i < `BOX_DIM) begin
                col_o.tap[r] = mem_q[src_row * `BOX_DIM + int'(feed_col_i)];
            end else begin
                col_o.tap[r] = '0;   // Above, below or right of the tile.
            end
        end
    end

endmodule

//--- window_7x7_datapath.sv
`include "box_cfg.svh"

module window_7x7_datapath #(
    parameter int ROWS = 7,
    parameter int COLS = 7
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  box_pkg::column_t      col_i,
    input  logic                  load_en_i,
    input  logic                  o_en_i,
    input  logic                  count_en_i,
    input  logic                  reset_en_i,
    output box_pkg::window_beat_t win_o,
    output logic                  finish_en_o,
    output logic                  padding_fi_o
);

    box_pkg::pixel_t [`BOX_DIM-1:0][`BOX_DIM-1:0] win_q;   // Column 6 holds the newest load.
    box_pkg::pixel_t [`BOX_DIM-1:0][`BOX_DIM-1:0] padded;
    box_pkg::coord_t                              row_q;
    box_pkg::coord_t                              col_q;
    logic [2:0]                                   pre_cnt_q;
    logic                                         col_last;

    assign col_last     = (col_q == COLS - 1);
    assign finish_en_o  = col_last && (row_q == ROWS - 1);
    assign padding_fi_o = (pre_cnt_q == 3'(`BOX_PRELOAD - 1));

    // Output position, stepped once per produced window.
    always_ff @(posedge clk) begin
        if (!rst_n || reset_en_i) begin
            row_q <= '0;
            col_q <= '0;
        end else if (o_en_i) begin
            if (col_last) begin
                col_q <= '0;
                row_q <= row_q + 1'b1;
            end else begin
                col_q <= col_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pre_cnt_q <= '0;
        end else if (count_en_i) begin
            pre_cnt_q <= pre_cnt_q + 1'b1;
        end else begin
            pre_cnt_q <= '0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            win_q <= '0;
        end else if (load_en_i) begin
            for (int r = 0; r < `BOX_DIM; r++) begin
                for (int k = 0; k < `BOX_DIM - 1; k++) begin
                    win_q[r][k] <= win_q[r][k+1];
                end
                win_q[r][`BOX_DIM-1] <= col_i.tap[r];
            end
        end
    end

    // Taps that land outside the tile read as zero.
    always_comb begin
        int tap_row;
        int tap_col;
        for (int r = 0; r < `BOX_DIM; r++) begin
            for (int k = 0; k < `BOX_DIM; k++) begin
                tap_row = int'(row_q) + r - `BOX_HALF;
                tap_col = int'(col_q) + k - `BOX_HALF;
                if (tap_row < 0 || tap_row >= ROWS || tap_col < 0 || tap_col >= COLS) begin
                    padded[r][k] = '0;
                end else begin
                    padded[r][k] = win_q[r][k];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            win_o <= '0;
        end else if (o_en_i) begin
            win_o.pix   <= padded;   // Sampled before this cycle's shift lands.
            win_o.row   <= row_q;
            win_o.col   <= col_q;
            win_o.valid <= 1'b1;
        end else begin
            win_o.valid <= 1'b0;
        end
    end

    // The sequencer must shift on every output cycle or the window falls behind.
    a_oen_with_load: assert property (@(posedge clk) disable iff (!rst_n)
        o_en_i |-> load_en_i)
        else $error("o_en without load_en");

endmodule

//--- box_pkg.sv
`include "box_cfg.svh"

package box_pkg;

    typedef logic [7:0]  pixel_t;
    typedef logic [2:0]  coord_t;
    typedef logic [13:0] result_t;
    typedef logic [15:0] wb_data_t;
    typedef logic [7:0]  wb_adr_t;

    // Tap 0 is the row three above the centre, tap 6 the row three below.
    typedef struct packed {
        pixel_t [`BOX_DIM-1:0] tap;
    } column_t;

    typedef struct packed {
        pixel_t [`BOX_DIM-1:0][`BOX_DIM-1:0] pix;  // [row offset][column offset].
        coord_t                              row;
        coord_t                              col;
        logic                                valid;
    } window_beat_t;

    typedef struct packed {
        result_t sum;
        coord_t  row;
        coord_t  col;
        logic    valid;
    } result_beat_t;

    typedef struct packed {
        logic       en;
        logic [5:0] idx;
        pixel_t     pix;
    } pixel_wr_t;

    typedef enum logic [2:0] {IDLE, CLEAR, PRELOAD, RUN, DRAIN, DONE} seq_state_t;

endpackage

//--- box_cfg.svh
`ifndef BOX_CFG_SVH
`define BOX_CFG_SVH

`define BOX_DIM      7
`define BOX_PIXELS   49
`define BOX_HALF     3      // Window radius around the centre tap.
`define BOX_PRELOAD  4
`define BOX_PIPE     3      // o_en to stored result.

// Word addresses on the slave bus.
`define BOX_ADR_CTRL 8'h40
`define BOX_ADR_STAT 8'h41
`define BOX_ADR_RES  8'h80

`endif
